/* Makefile */
TOP = tb_core

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* dv/core_model.svh */
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// instruction-level model of the rv32i subset, one step per instruction

word_t   model_regs [32];
word_t   model_dmem [DMEM_WORDS];
commit_t exp_commit [$];
word_t   exp_ins [$];     // kept to name a failing check
word_t   exp_st_addr [$];
word_t   exp_st_data [$];

function automatic word_t model_alu(logic [2:0] f3, logic sub, word_t a, word_t b);
  word_t r;
  case (f3)
    F3_ADD:  r = sub ? a - b : a + b;
    F3_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    F3_XOR:  r = a ^ b;
    F3_OR:   r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

task automatic run_model();
  word_t   pc, ins, a, b, res, nxt, addr;
  word_t   imm_i, imm_s, imm_b, imm_j;
  regid_t  rd;
  logic    wr, taken;
  commit_t c;
  int      i, steps;
  for (i = 0; i < 32; i++) begin
    model_regs[i] = '0;
  end
  for (i = 0; i < DMEM_WORDS; i++) begin
    model_dmem[i] = fill_word(word_t'(i * 4));
  end
  pc    = RESET_PC;
  steps = 0;
  // forward-only control flow, always reaches the end
  while ((pc < word_t'(PROG_LEN * 4)) && (steps < PROG_LEN)) begin
    ins   = imem[pc[7:2]];
    rd    = ins[11:7];
    a     = model_regs[ins[19:15]];
    b     = model_regs[ins[24:20]];
    imm_i = {{20{ins[31]}}, ins[31:20]};
    imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    wr    = 1'b0;
    res   = '0;
    nxt   = pc + 32'd4;
    case (ins[6:0])
      OPC_LUI: begin
        res = {ins[31:12], 12'h000};
        wr  = 1'b1;
      end
      OPC_OPIMM: begin
        res = model_alu(ins[14:12], 1'b0, a, imm_i);
        wr  = 1'b1;
      end
      OPC_OP: begin
        res = model_alu(ins[14:12], ins[30], a, b); // bit 30 marks sub
        wr  = 1'b1;
      end
      OPC_LOAD: begin
        addr = a + imm_i;
        res  = model_dmem[addr[6:2]];
        wr   = 1'b1;
      end
      OPC_STORE: begin
        addr = a + imm_s;
        model_dmem[addr[6:2]] = b;
        exp_st_addr.push_back(addr);
        exp_st_data.push_back(b);
      end
      OPC_BRANCH: begin
        case (ins[14:12])
          F3_BEQ:  taken = a == b;
          F3_BNE:  taken = a != b;
          default: taken = $signed(a) < $signed(b);
        endcase
        if (taken) begin
          nxt = pc + imm_b;
        end
      end
      OPC_JAL: begin
        res = pc + 32'd4;
        wr  = 1'b1;
        nxt = pc + imm_j;
      end
      default: ;
    endcase
    if (wr && (rd != 5'd0)) begin
      model_regs[rd] = res;
    end
    c.valid = 1'b1;
    c.pc    = pc;
    c.rdid  = rd;
    c.rdwen = wr && (rd != 5'd0);
    c.rd    = res;
    exp_commit.push_back(c);
    exp_ins.push_back(ins);
    pc    = nxt;
    steps = steps + 1;
  end
endtask

`endif

/* dv/tb_core.sv */
module tb_core import rv_isa_pkg::*, core_pkg::*; ();

  localparam int    PROG_LEN   = 56;
  localparam int    IMEM_WORDS = 64;
  localparam int    DMEM_WORDS = 32;
  localparam int    TIMEOUT    = 1000;
  localparam word_t NOP_INS    = 32'h0000_0013; // addi x0, x0, 0

  logic      clk;
  logic      rst;
  word_t     imem_addr, imem_data, dmem_rdata;
  dmem_req_t dmem_req;
  commit_t   commit;
  word_t     imem [IMEM_WORDS];
  word_t     dmem [DMEM_WORDS];
  word_t     rng_state;
  int        commit_idx, store_idx;

  core_top dut (
    .i_clk        (clk       ),
    .i_rst        (rst       ),
    .o_imem_addr  (imem_addr ),
    .i_imem_data  (imem_data ),
    .o_dmem_req   (dmem_req  ),
    .i_dmem_rdata (dmem_rdata),
    .o_commit     (commit    )
  );

  always #20 clk = ~clk;

  // combinational memories, stores land on the rising edge
  assign imem_data  = (imem_addr < 32'(IMEM_WORDS * 4)) ? imem[imem_addr[7:2]] : NOP_INS;
  assign dmem_rdata = dmem[dmem_req.addr[6:2]];

  always @(posedge clk) begin
    if (dmem_req.wen) begin
      dmem[dmem_req.addr[6:2]] <= dmem_req.wdata;
    end
  end

  function automatic word_t fill_word(word_t addr);
    return 32'hc0de_0000 ^ (addr * 32'h0001_0203);
  endfunction

  function automatic word_t lcg_next();
    rng_state = rng_state * 32'd1103515245 + 32'd12345;
    return rng_state;
  endfunction

  function automatic int pick(int n);
    word_t r;
    r = lcg_next();
    return int'(r[31:16]) % n; // low lcg bits are weak
  endfunction

  function automatic word_t itype_word(logic [11:0] imm, regid_t rs1, logic [2:0] f3,
                                       regid_t rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t rtype_word(logic [6:0] f7, regid_t rs2, regid_t rs1,
                                       logic [2:0] f3, regid_t rd);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic word_t store_word(logic [11:0] imm, regid_t rs2);
    return {imm[11:5], rs2, 5'd0, F3_W, imm[4:0], OPC_STORE};
  endfunction

  function automatic word_t branch_word(logic [12:0] off, regid_t rs1, regid_t rs2,
                                        logic [2:0] f3);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic word_t jal_word(logic [20:0] off, regid_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
  endfunction

  // x0..x7 only, rs1 often reuses the last rd to hit forwarding and load-use
  function automatic word_t random_ins(int idx, regid_t prev_rd);
    word_t      r, v, w;
    regid_t     rd, rs1, rs2;
    logic [2:0] f3, bf3;
    int         k;
    r   = lcg_next();
    v   = lcg_next();
    rd  = {2'b00, r[18:16]};
    rs1 = r[19] ? prev_rd : {2'b00, r[22:20]};
    rs2 = {2'b00, r[25:23]};
    case (pick(5))
      0:       f3 = F3_ADD;
      1:       f3 = F3_SLT;
      2:       f3 = F3_XOR;
      3:       f3 = F3_OR;
      default: f3 = F3_AND;
    endcase
    bf3 = (v[31:30] == 2'd0) ? F3_BEQ : ((v[31:30] == 2'd1) ? F3_BNE : F3_BLT);
    k   = 1 + pick(4);
    if (k > PROG_LEN - idx) begin
      k = PROG_LEN - idx; // never jump past the program end
    end
    case (pick(10))
      0:       w = {v[31:12], rd, OPC_LUI};
      1, 2:    w = itype_word(v[31:20], rs1, f3, rd, OPC_OPIMM);
      3, 4:    w = rtype_word(((f3 == F3_ADD) && v[31]) ? F7_SUB : F7_BASE, rs2, rs1, f3, rd);
      5:       w = itype_word({5'd0, v[31:27], 2'b00}, 5'd0, F3_W, rd, OPC_LOAD);
      6:       w = store_word({5'd0, v[31:27], 2'b00}, rs2);
      7, 8:    w = branch_word(13'(k * 4), rs1, rs2, bf3);
      default: w = jal_word(21'(k * 4), rd);
    endcase
    return w;
  endfunction

  task automatic build_program();
    int     i;
    regid_t last_rd;
    last_rd = '0;
    for (i = 0; i < 7; i++) begin
      imem[i] = itype_word(12'(pick(4096)), 5'd0, F3_ADD, regid_t'(i + 1), OPC_OPIMM);
    end
    for (i = 7; i < PROG_LEN; i++) begin
      imem[i] = random_ins(i, last_rd);
      // stores and branches carry immediate bits in the rd field
      if (!(imem[i][6:0] inside {OPC_STORE, OPC_BRANCH})) begin
        last_rd = imem[i][11:7];
      end
    end
    for (i = PROG_LEN; i < IMEM_WORDS; i++) begin
      imem[i] = NOP_INS;
    end
  endtask

  `include "core_model.svh"

  task automatic abort_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic report_value(string name, word_t expected, word_t actual);
    $display("Fail %s: expected %h actual %h", name, expected, actual);
    abort_run();
  endtask

  task automatic report_problem(string what);
    $display("%s", what);
    abort_run();
  endtask

  function automatic string test_name(word_t ins);
    string s;
    case (ins[6:0])
      OPC_LOAD, OPC_STORE: s = "load_store";
      OPC_BRANCH, OPC_JAL: s = "control_flow";
      default:             s = "alu_forward";
    endcase
    if ((ins[11:7] == 5'd0) &&
        (ins[6:0] inside {OPC_LUI, OPC_OPIMM, OPC_OP, OPC_LOAD, OPC_JAL})) begin
      s = "x0";
    end
    return s;
  endfunction

  task automatic check_quiet();
    assert (commit.valid === 1'b0) else report_value("reset", 32'd0, word_t'(commit.valid));
    assert (dmem_req.ren === 1'b0) else report_value("reset", 32'd0, word_t'(dmem_req.ren));
    assert (dmem_req.wen === 1'b0) else report_value("reset", 32'd0, word_t'(dmem_req.wen));
  endtask

  task automatic check_commit(int n);
    commit_t e;
    string   name;
    e    = exp_commit[n];
    name = test_name(exp_ins[n]);
    if (n == 0) begin
      assert (commit.pc == RESET_PC) else report_value("reset", RESET_PC, commit.pc);
    end
    assert (commit.pc == e.pc) else report_value("control_flow", e.pc, commit.pc);
    assert (commit.rdwen == e.rdwen)
      else report_value(name, word_t'(e.rdwen), word_t'(commit.rdwen));
    if (e.rdwen) begin
      assert (commit.rdid == e.rdid)
        else report_value(name, word_t'(e.rdid), word_t'(commit.rdid));
      assert (commit.rd == e.rd) else report_value(name, e.rd, commit.rd);
    end
  endtask

  task automatic check_store();
    if (store_idx >= exp_st_addr.size()) begin
      report_problem("load_store: the core wrote memory where the model has no store");
    end else begin
      assert (dmem_req.addr == exp_st_addr[store_idx])
        else report_value("load_store", exp_st_addr[store_idx], dmem_req.addr);
      assert (dmem_req.wdata == exp_st_data[store_idx])
        else report_value("load_store", exp_st_data[store_idx], dmem_req.wdata);
      store_idx = store_idx + 1;
    end
  endtask

  // outputs are settled by the falling edge
  always @(negedge clk) begin
    if (!rst) begin
      if (commit.valid && (commit_idx < exp_commit.size())) begin
        check_commit(commit_idx);
        commit_idx = commit_idx + 1;
      end
      if (dmem_req.wen) begin
        check_store();
      end
    end
  end

  initial begin
    int i;
    int cycles;
    clk        = 1'b0;
    rst        = 1'b1;
    rng_state  = 32'h89e8;
    commit_idx = 0;
    store_idx  = 0;
    build_program();
    for (i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = fill_word(word_t'(i * 4));
    end
    run_model();

    repeat (16) begin
      @(negedge clk);
      check_quiet();
    end
    rst <= 1'b0;
    repeat (3) begin // nothing can reach writeback yet
      @(negedge clk);
      check_quiet();
    end

    cycles = 0;
    while ((commit_idx < exp_commit.size()) && (cycles < TIMEOUT)) begin
      @(negedge clk);
      cycles = cycles + 1;
    end

    if (commit_idx < exp_commit.size()) begin
      report_problem("completion: the core stopped committing before the program ended");
    end else begin
      assert (store_idx == exp_st_addr.size())
        else report_value("load_store", word_t'(exp_st_addr.size()), word_t'(store_idx));
      for (i = 0; i < DMEM_WORDS; i++) begin
        assert (dmem[i] == model_dmem[i]) else report_value("completion", model_dmem[i], dmem[i]);
      end
      $display("Simulation finished: PASS");
      $finish;
    end
  end

endmodule

/* project.f */
+incdir+dv
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/ifu.sv
verilog/idu.sv
verilog/bru.sv
verilog/exu.sv
verilog/lsu.sv
verilog/bypass.sv
verilog/core_top.sv
dv/tb_core.sv

/* verilog/bru.sv */
module bru import rv_isa_pkg::*, core_pkg::*; (
  input  logic       i_valid,
  input  logic       i_is_jal,
  input  logic       i_is_branch,
  input  logic [2:0] i_bfunc3,
  input  word_t      i_rs1,
  input  word_t      i_rs2,
  input  word_t      i_pc,
  input  word_t      i_imm,
  input  logic       i_stall,
  output logic       o_redirect,
  output word_t      o_target_pc
);

  logic taken;

  // operands arrive already forwarded
  always_comb begin
    case (i_bfunc3)
      F3_BEQ:  taken = i_rs1 == i_rs2;
      F3_BNE:  taken = i_rs1 != i_rs2;
      F3_BLT:  taken = $signed(i_rs1) < $signed(i_rs2);
      default: taken = 1'b0;
    endcase
  end

  // a stalled branch may still see a stale operand, so hold off
  assign o_redirect  = i_valid && !i_stall && (i_is_jal || (i_is_branch && taken));
  assign o_target_pc = i_pc + i_imm;

endmodule

/* verilog/bypass.sv */
module bypass import core_pkg::*; (
  input  logic   i_clk,
  input  logic   i_rst,
  input  regid_t i_rs1id,
  input  regid_t i_rs2id,
  input  logic   i_rs1_used,
  input  logic   i_rs2_used,
  input  fwd_t   i_ex_fwd,
  input  fwd_t   i_ls_fwd,
  input  fwd_t   i_wb_fwd,
  input  logic   i_ex_is_load,
  output word_t  o_rs1,
  output word_t  o_rs2,
  output logic   o_stall
);

  word_t regs [1:31]; // x0 hardwired
  logic  hit1, hit2;

  always_ff @(posedge i_clk) begin
    if (!i_rst && i_wb_fwd.wen && (i_wb_fwd.rdid != '0)) begin
      regs[i_wb_fwd.rdid] <= i_wb_fwd.value;
    end
  end

  // youngest producer wins
  function automatic word_t resolve(regid_t id);
    word_t v;
    if (id == '0) begin
      v = '0;
    end else if (i_ex_fwd.wen && !i_ex_is_load && (i_ex_fwd.rdid == id)) begin
      v = i_ex_fwd.value;
    end else if (i_ls_fwd.wen && (i_ls_fwd.rdid == id)) begin
      v = i_ls_fwd.value;
    end else if (i_wb_fwd.wen && (i_wb_fwd.rdid == id)) begin
      v = i_wb_fwd.value; // write lands this edge
    end else begin
      v = regs[id];
    end
    return v;
  endfunction

  always_comb begin
    o_rs1 = resolve(i_rs1id);
    o_rs2 = resolve(i_rs2id);
  end

  // load data not ready until ls
  assign hit1    = i_rs1_used && (i_rs1id == i_ex_fwd.rdid);
  assign hit2    = i_rs2_used && (i_rs2id == i_ex_fwd.rdid);
  assign o_stall = i_ex_is_load && i_ex_fwd.wen && (i_ex_fwd.rdid != '0) && (hit1 || hit2);

endmodule

/* verilog/core_pkg.sv */
package core_pkg;
  import rv_isa_pkg::*;

  localparam int XLEN      = 32;
  localparam int REG_ADDRW = 5;
  localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

  typedef logic [XLEN-1:0]      word_t;
  typedef logic [REG_ADDRW-1:0] regid_t;

  typedef struct packed {
    word_t pc;
    word_t ins;
  } fetch_t;

  typedef struct packed {
    word_t   pc;
    word_t   rs1;
    word_t   rs2;
    word_t   imm;
    alu_op_e alu_op;
    logic    bimm;   // operand b from imm
    logic    link;   // jal, rd gets pc+4
    logic    lden;
    logic    sten;
    regid_t  rdid;
    logic    rdwen;
  } idex_t;

  typedef struct packed {
    word_t  pc;
    word_t  exres;   // alu result or memory address
    word_t  stdata;
    logic   lden;
    logic   sten;
    regid_t rdid;
    logic   rdwen;
  } exls_t;

  typedef struct packed {
    word_t  pc;
    word_t  rd;
    regid_t rdid;
    logic   rdwen;
  } lswb_t;

  typedef struct packed {
    logic  ren;
    logic  wen;
    word_t addr;
    word_t wdata;
  } dmem_req_t;

  typedef struct packed {
    logic   valid;
    word_t  pc;
    regid_t rdid;
    logic   rdwen;
    word_t  rd;
  } commit_t;

  typedef struct packed {
    logic   wen;
    regid_t rdid;
    word_t  value;
  } fwd_t;

endpackage

/* verilog/core_top.sv */
module core_top import core_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  output word_t     o_imem_addr,
  input  word_t     i_imem_data,
  output dmem_req_t o_dmem_req,
  input  word_t     i_dmem_rdata,
  output commit_t   o_commit
);

  fetch_t fetch;
  logic   fetch_valid;
  logic   stall_id, redirect;
  word_t  target_pc;

  regid_t rs1id, rs2id;
  logic   rs1_used, rs2_used;
  word_t  rs1_val, rs2_val, imm;
  logic   is_jal, is_branch;
  logic [2:0] bfunc3;

  idex_t idex;
  logic  idex_valid;
  exls_t exls;
  logic  exls_valid;
  fwd_t  ex_fwd, ls_fwd, wb_fwd;
  logic  ex_is_load;

  ifu u_ifu (
    .i_clk         (i_clk        ),
    .i_rst         (i_rst        ),
    .i_stall       (stall_id     ),
    .i_redirect    (redirect     ),
    .i_target_pc   (target_pc    ),
    .o_imem_addr   (o_imem_addr  ),
    .i_imem_data   (i_imem_data  ),
    .o_fetch       (fetch        ),
    .o_fetch_valid (fetch_valid  )
  );

  idu u_idu (
    .i_clk         (i_clk        ),
    .i_rst         (i_rst        ),
    .i_fetch       (fetch        ),
    .i_fetch_valid (fetch_valid  ),
    .i_stall       (stall_id     ),
    .o_rs1id       (rs1id        ),
    .o_rs2id       (rs2id        ),
    .o_rs1_used    (rs1_used     ),
    .o_rs2_used    (rs2_used     ),
    .i_rs1         (rs1_val      ),
    .i_rs2         (rs2_val      ),
    .o_is_jal      (is_jal       ),
    .o_is_branch   (is_branch    ),
    .o_bfunc3      (bfunc3       ),
    .o_imm         (imm          ),
    .o_idex        (idex         ),
    .o_idex_valid  (idex_valid   )
  );

  // resolved in decode, one squashed slot
  bru u_bru (
    .i_valid       (fetch_valid  ),
    .i_is_jal      (is_jal       ),
    .i_is_branch   (is_branch    ),
    .i_bfunc3      (bfunc3       ),
    .i_rs1         (rs1_val      ),
    .i_rs2         (rs2_val      ),
    .i_pc          (fetch.pc     ),
    .i_imm         (imm          ),
    .i_stall       (stall_id     ),
    .o_redirect    (redirect     ),
    .o_target_pc   (target_pc    )
  );

  exu u_exu (
    .i_clk         (i_clk        ),
    .i_rst         (i_rst        ),
    .i_idex        (idex         ),
    .i_idex_valid  (idex_valid   ),
    .o_exls        (exls         ),
    .o_exls_valid  (exls_valid   ),
    .o_ex_fwd      (ex_fwd       ),
    .o_ex_is_load  (ex_is_load   )
  );

  lsu u_lsu (
    .i_clk         (i_clk        ),
    .i_rst         (i_rst        ),
    .i_exls        (exls         ),
    .i_exls_valid  (exls_valid   ),
    .o_dmem_req    (o_dmem_req   ),
    .i_dmem_rdata  (i_dmem_rdata ),
    .o_ls_fwd      (ls_fwd       ),
    .o_wb_fwd      (wb_fwd       ),
    .o_commit      (o_commit     )
  );

  bypass u_bypass (
    .i_clk         (i_clk        ),
    .i_rst         (i_rst        ),
    .i_rs1id       (rs1id        ),
    .i_rs2id       (rs2id        ),
    .i_rs1_used    (rs1_used     ),
    .i_rs2_used    (rs2_used     ),
    .i_ex_fwd      (ex_fwd       ),
    .i_ls_fwd      (ls_fwd       ),
    .i_wb_fwd      (wb_fwd       ),
    .i_ex_is_load  (ex_is_load   ),
    .o_rs1         (rs1_val      ),
    .o_rs2         (rs2_val      ),
    .o_stall       (stall_id     )
  );

endmodule

/* verilog/exu.sv */
module exu import rv_isa_pkg::*, core_pkg::*; (
  input  logic  i_clk,
  input  logic  i_rst,
  input  idex_t i_idex,
  input  logic  i_idex_valid,
  output exls_t o_exls,
  output logic  o_exls_valid,
  output fwd_t  o_ex_fwd,
  output logic  o_ex_is_load
);

  word_t opb, alu_res, exres;

  assign opb = i_idex.bimm ? i_idex.imm : i_idex.rs2;

  always_comb begin
    case (i_idex.alu_op)
      ALU_ADD:   alu_res = i_idex.rs1 + opb;
      ALU_SUB:   alu_res = i_idex.rs1 - opb;
      ALU_AND:   alu_res = i_idex.rs1 & opb;
      ALU_OR:    alu_res = i_idex.rs1 | opb;
      ALU_XOR:   alu_res = i_idex.rs1 ^ opb;
      ALU_SLT:   alu_res = {{(XLEN-1){1'b0}}, $signed(i_idex.rs1) < $signed(opb)};
      ALU_PASSB: alu_res = opb;
      default:   alu_res = '0;
    endcase
  end

  assign exres = i_idex.link ? i_idex.pc + 32'd4 : alu_res;

  // loads included so bypass can spot load-use
  assign o_ex_fwd     = '{wen: i_idex_valid && i_idex.rdwen, rdid: i_idex.rdid, value: exres};
  assign o_ex_is_load = i_idex_valid && i_idex.lden;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_exls_valid <= 1'b0;
    end else begin
      o_exls_valid <= i_idex_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    o_exls.pc     <= i_idex.pc;
    o_exls.exres  <= exres;
    o_exls.stdata <= i_idex.rs2;
    o_exls.lden   <= i_idex.lden;
    o_exls.sten   <= i_idex.sten;
    o_exls.rdid   <= i_idex.rdid;
    o_exls.rdwen  <= i_idex.rdwen;
  end

endmodule

/* verilog/idu.sv */
module idu import rv_isa_pkg::*, core_pkg::*; (
  input  logic       i_clk,
  input  logic       i_rst,
  input  fetch_t     i_fetch,
  input  logic       i_fetch_valid,
  input  logic       i_stall,
  output regid_t     o_rs1id,
  output regid_t     o_rs2id,
  output logic       o_rs1_used,
  output logic       o_rs2_used,
  input  word_t      i_rs1,
  input  word_t      i_rs2,
  output logic       o_is_jal,
  output logic       o_is_branch,
  output logic [2:0] o_bfunc3,
  output word_t      o_imm,
  output idex_t      o_idex,
  output logic       o_idex_valid
);

  word_t      ins;
  logic [6:0] opc, f7;
  logic [2:0] f3;
  logic       alu_f3_ok, is_lui, is_opimm, is_op, is_load, is_store;
  alu_op_e    f3_op;
  idex_t      idex_d;

  assign ins = i_fetch.ins;
  assign opc = ins[6:0];
  assign f3  = ins[14:12];
  assign f7  = ins[31:25];

  // anything not matched here falls through as a nop
  always_comb begin
    alu_f3_ok   = f3 inside {F3_ADD, F3_SLT, F3_XOR, F3_OR, F3_AND};
    is_lui      = opc == OPC_LUI;
    is_opimm    = (opc == OPC_OPIMM) && alu_f3_ok;
    is_op       = (opc == OPC_OP) && alu_f3_ok &&
                  ((f7 == F7_BASE) || ((f7 == F7_SUB) && (f3 == F3_ADD)));
    is_load     = (opc == OPC_LOAD) && (f3 == F3_W);
    is_store    = (opc == OPC_STORE) && (f3 == F3_W);
    o_is_branch = (opc == OPC_BRANCH) && (f3 inside {F3_BEQ, F3_BNE, F3_BLT});
    o_is_jal    = opc == OPC_JAL;
  end

  assign o_rs1id    = ins[19:15];
  assign o_rs2id    = ins[24:20];
  assign o_rs1_used = i_fetch_valid && (is_opimm || is_op || is_load || is_store || o_is_branch);
  assign o_rs2_used = i_fetch_valid && (is_op || is_store || o_is_branch);
  assign o_bfunc3   = f3;

  always_comb begin
    if (is_lui) begin
      o_imm = {ins[31:12], 12'b0};
    end else if (is_store) begin
      o_imm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    end else if (o_is_branch) begin
      o_imm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    end else if (o_is_jal) begin
      o_imm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
    end else begin
      o_imm = {{20{ins[31]}}, ins[31:20]}; // i-type
    end
  end

  always_comb begin
    case (f3)
      F3_ADD:  f3_op = (is_op && (f7 == F7_SUB)) ? ALU_SUB : ALU_ADD;
      F3_SLT:  f3_op = ALU_SLT;
      F3_XOR:  f3_op = ALU_XOR;
      F3_OR:   f3_op = ALU_OR;
      F3_AND:  f3_op = ALU_AND;
      default: f3_op = ALU_ADD;
    endcase
  end

  always_comb begin
    idex_d.pc     = i_fetch.pc;
    idex_d.rs1    = i_rs1;
    idex_d.rs2    = i_rs2;
    idex_d.imm    = o_imm;
    idex_d.alu_op = is_lui ? ALU_PASSB : ((is_opimm || is_op) ? f3_op : ALU_ADD);
    idex_d.bimm   = !is_op;
    idex_d.link   = o_is_jal;
    idex_d.lden   = is_load;
    idex_d.sten   = is_store;
    idex_d.rdid   = ins[11:7];
    // x0 writes dropped here
    idex_d.rdwen  = (is_lui || is_opimm || is_op || is_load || o_is_jal) && (ins[11:7] != '0);
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_idex_valid <= 1'b0;
    end else begin
      o_idex_valid <= i_fetch_valid && !i_stall; // bubble on load-use
    end
  end

  always_ff @(posedge i_clk) begin
    o_idex <= idex_d;
  end

endmodule

/* verilog/ifu.sv */
module ifu import core_pkg::*; (
  input  logic   i_clk,
  input  logic   i_rst,
  input  logic   i_stall,
  input  logic   i_redirect,
  input  word_t  i_target_pc,
  output word_t  o_imem_addr,
  input  word_t  i_imem_data,
  output fetch_t o_fetch,
  output logic   o_fetch_valid
);

  word_t pc;

  assign o_imem_addr = pc;

  // redirect never comes with stall
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc <= RESET_PC;
    end else if (i_redirect) begin
      pc <= i_target_pc;
    end else if (!i_stall) begin
      pc <= pc + 32'd4;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_fetch_valid <= 1'b0;
    end else if (i_redirect) begin
      o_fetch_valid <= 1'b0; // wrong-path slot
    end else if (!i_stall) begin
      o_fetch_valid <= 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_stall) begin
      o_fetch.pc  <= pc;
      o_fetch.ins <= i_imem_data;
    end
  end

endmodule

/* verilog/lsu.sv */
module lsu import core_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  exls_t     i_exls,
  input  logic      i_exls_valid,
  output dmem_req_t o_dmem_req,
  input  word_t     i_dmem_rdata,
  output fwd_t      o_ls_fwd,
  output fwd_t      o_wb_fwd,
  output commit_t   o_commit
);

  word_t rd_val;
  lswb_t lswb;
  logic  wb_valid;

  // word access only, address straight from the alu
  assign o_dmem_req.ren   = i_exls_valid && i_exls.lden;
  assign o_dmem_req.wen   = i_exls_valid && i_exls.sten;
  assign o_dmem_req.addr  = i_exls.exres;
  assign o_dmem_req.wdata = i_exls.stdata;

  assign rd_val = i_exls.lden ? i_dmem_rdata : i_exls.exres;

  assign o_ls_fwd = '{wen: i_exls_valid && i_exls.rdwen, rdid: i_exls.rdid, value: rd_val};

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= i_exls_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    lswb.pc    <= i_exls.pc;
    lswb.rd    <= rd_val;
    lswb.rdid  <= i_exls.rdid;
    lswb.rdwen <= i_exls.rdwen;
  end

  // same register drives the regfile write and the trace
  assign o_wb_fwd = '{wen: wb_valid && lswb.rdwen, rdid: lswb.rdid, value: lswb.rd};

  assign o_commit = '{
    valid: wb_valid,
    pc:    lswb.pc,
    rdid:  lswb.rdid,
    rdwen: lswb.rdwen,
    rd:    lswb.rd
  };

endmodule

/* verilog/rv_isa_pkg.sv */
package rv_isa_pkg;

  // major opcodes, ins[6:0]
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  // alu funct3
  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  // branch funct3
  localparam logic [2:0] F3_BEQ = 3'b000;
  localparam logic [2:0] F3_BNE = 3'b001;
  localparam logic [2:0] F3_BLT = 3'b100;

  localparam logic [2:0] F3_W = 3'b010; // lw / sw only

  // funct7 of register-register ops
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_PASSB // lui
  } alu_op_e;

endpackage
